// File: design/decode_params.svh
// Sizing macros for the issue stage; include wherever slot, ROB or tag dimensions are needed
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Instruction-buffer slots examined per cycle
`define ISSUE_WIDTH 4

// Reorder buffer depth
// Tags run from 1 to ROB_ENTRIES, tag 0 never names an entry
`define ROB_ENTRIES 8

`define TAG_W 6 // Tag width seen by stations and register status

// Fetch PC has already moved three words past slot 0 when a bundle arrives,
// so branch targets are taken relative to fetchPc minus this lead
`define PC_FETCH_LEAD 12

`endif

// File: design/isaPkg.sv
// MIPS subset encodings and field widths; import in modules that decode or carry operations
package isaPkg;

	localparam int opcodeW = 6;
	localparam int functW = 6;
	localparam int regW = 5;
	localparam int immW = 16;
	localparam int intOpW = 5;

	typedef enum logic [opcodeW-1:0] {
		opcRtype = 6'h00,
		opcBeq = 6'h04,
		opcBne = 6'h05,
		opcAddi = 6'h08,
		opcSlti = 6'h0a,
		opcAndi = 6'h0c,
		opcOri = 6'h0d,
		opcLw = 6'h23,
		opcSw = 6'h2b
	} opcodeE;

	typedef enum logic [functW-1:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr = 6'h25,
		fnSlt = 6'h2a
	} functE;

	// Bit 4 set means immediate form, result goes to rt
	typedef enum logic [intOpW-1:0] {
		opAdd = 5'h00,
		opSub = 5'h01,
		opAnd = 5'h02,
		opOr = 5'h03,
		opSlt = 5'h04,
		opBeq = 5'h05,
		opBne = 5'h06,
		opNop = 5'h07,
		opAddi = 5'h10,
		opSlti = 5'h11,
		opAndi = 5'h12,
		opOri = 5'h13
	} intOpE;

	typedef logic [regW-1:0] regIdxT;

endpackage

// File: design/issuePkg.sv
// Issue-side types shared by the RTL and testbench; import where packets or ROB data are used
`include "decode_params.svh"

package issuePkg;
	import isaPkg::*;

	typedef enum logic [1:0] {
		clsArith,
		clsBranch,
		clsLoad,
		clsStore
	} instClassE;

	// Loads report as arithmetic to the ROB
	typedef enum logic [2:0] {
		robArith = 3'd0,
		robBranch = 3'd1,
		robStore = 3'd2
	} robOpE;

	typedef enum logic [1:0] {stInt0, stInt1, stLoad, stStore} stationE;

	typedef logic [`TAG_W-1:0] robTagT;

	localparam int robHeadW = $clog2(`ROB_ENTRIES);

	typedef struct packed {
		logic valid;
		intOpE intOp;
		logic [immW-1:0] imm;
		regIdxT srcA; // rs
		regIdxT srcB; // rt
		robTagT tag;
	} stationPktT;

	typedef struct packed {
		logic valid;
		robOpE opType;
		logic [31:0] dest; // Register number or branch target
	} robEntryT;

	typedef struct packed {
		logic valid;
		regIdxT regId;
		robTagT tag;
	} renameT;

	// Tag of the k-th slot, wraps inside the ROB and never yields 0
	function automatic robTagT slotTag(input logic [robHeadW-1:0] head, input int unsigned k);
		return robTagT'((32'(head) + k) % `ROB_ENTRIES + 1);
	endfunction

endpackage

// File: design/issueIfs.sv
// Interfaces between the issue-stage blocks: one slotIf per decoded slot and one grantIf
`timescale 1ns/1ps
`include "decode_params.svh"

interface slotIf
	import isaPkg::*;
	import issuePkg::*;
();
	logic valid;
	instClassE cls;
	intOpE intOp;
	regIdxT rs;
	regIdxT rt;
	regIdxT destReg;
	logic writesReg;
	logic [immW-1:0] imm;

	modport source (output valid, cls, intOp, rs, rt, destReg, writesReg, imm);
	modport sink (input valid, cls, intOp, rs, rt, destReg, writesReg, imm);
endinterface

interface grantIf
	import issuePkg::*;
();
	logic [`ISSUE_WIDTH-1:0] grant;
	stationE station [`ISSUE_WIDTH]; // Only meaningful where grant is set
	logic [2:0] count;

	modport source (output grant, station, count);
	modport sink (input grant, station, count);
endinterface

// File: design/slotDecoder.sv
// Combinational decode of one instruction-buffer word; one instance per issue slot
`timescale 1ns/1ps

module slotDecoder
	import isaPkg::*;
	import issuePkg::*;
(
	input logic [31:0] instWord,
	input logic instValid,
	slotIf.source slot
);
	logic [opcodeW-1:0] opcode;
	logic [functW-1:0] funct;
	regIdxT rs;
	regIdxT rt;
	regIdxT rd;
	instClassE cls;
	intOpE intOp;

	assign opcode = instWord[31:26];
	assign funct = instWord[5:0];
	assign rs = instWord[25:21];
	assign rt = instWord[20:16];
	assign rd = instWord[15:11];

	always_comb
	begin
		cls = clsArith;
		intOp = opNop;
		case (opcode)
			opcRtype:
			begin
				case (funct)
					fnAdd: intOp = opAdd;
					fnSub: intOp = opSub;
					fnAnd: intOp = opAnd;
					fnOr: intOp = opOr;
					fnSlt: intOp = opSlt;
					default: intOp = opNop;
				endcase
			end
			opcAddi: intOp = opAddi;
			opcSlti: intOp = opSlti;
			opcAndi: intOp = opAndi;
			opcOri: intOp = opOri;
			opcBeq:
			begin
				cls = clsBranch;
				intOp = opBeq;
			end
			opcBne:
			begin
				cls = clsBranch;
				intOp = opBne;
			end
			opcLw: cls = clsLoad;
			opcSw: cls = clsStore;
			default: intOp = opNop; // Unknown opcode runs as an arithmetic no-op
		endcase
	end

	assign slot.valid = instValid;
	assign slot.cls = cls;
	assign slot.intOp = intOp;
	assign slot.rs = rs;
	assign slot.rt = rt;
	// Immediate forms and loads write rt, everything else rd
	assign slot.destReg = (intOp[4] || cls == clsLoad) ? rt : rd;
	assign slot.writesReg = (cls == clsArith) || (cls == clsLoad);
	assign slot.imm = instWord[15:0];

endmodule

// File: design/issueArbiter.sv
// In-order issue decision for the four slots; picks a station per slot and the issue count
`timescale 1ns/1ps
`include "decode_params.svh"

module issueArbiter
	import issuePkg::*;
(
	input logic clk,
	input logic rst,
	slotIf.sink slots [`ISSUE_WIDTH],
	input logic [4:0] robFree,
	input logic int0Busy,
	input logic int1Busy,
	input logic loadBusy,
	input logic storeBusy,
	grantIf.source grants
);
	logic slotValid [`ISSUE_WIDTH];
	instClassE slotCls [`ISSUE_WIDTH];
	logic [3:0] busy;
	logic [3:0] claimed; // Stations already taken this cycle
	logic [`ISSUE_WIDTH-1:0] grant;
	stationE station [`ISSUE_WIDTH];
	stationE pick;
	logic [2:0] count;
	logic inOrder;

	for (genvar k = 0; k < `ISSUE_WIDTH; k++)
	begin : gSlot
		assign slotValid[k] = slots[k].valid;
		assign slotCls[k] = slots[k].cls;
	end

	assign busy = {storeBusy, loadBusy, int1Busy, int0Busy}; // Indexed by stationE

	always_comb
	begin
		claimed = '0;
		inOrder = 1'b1;
		count = '0;
		for (int k = 0; k < `ISSUE_WIDTH; k++)
		begin
			grant[k] = 1'b0;
			case (slotCls[k])
				clsLoad: pick = stLoad;
				clsStore: pick = stStore;
				// Integer and branch work prefers int0
				default: pick = (busy[stInt0] || claimed[stInt0]) ? stInt1 : stInt0;
			endcase
			station[k] = pick;
			if (inOrder && slotValid[k] && robFree > 5'(k) && !busy[pick] && !claimed[pick])
			begin
				grant[k] = 1'b1;
				claimed[pick] = 1'b1;
				count = count + 3'd1;
			end
			inOrder = grant[k]; // First blocked slot stops the rest
		end
	end

	assign grants.grant = grant;
	assign grants.station = station;
	assign grants.count = count;

	// Granted slots are a prefix from slot 0 and match the count the PC advances by
	assert property (@(posedge clk) disable iff (rst)
		grant == `ISSUE_WIDTH'((5'd1 << count) - 5'd1));

endmodule

// File: design/stationDispatch.sv
// Builds and registers one packet per reservation station from the granted slots
`timescale 1ns/1ps
`include "decode_params.svh"

module stationDispatch
	import isaPkg::*;
	import issuePkg::*;
(
	input logic clk,
	input logic rst,
	slotIf.sink slots [`ISSUE_WIDTH],
	grantIf.sink grants,
	input logic [robHeadW-1:0] robHead,
	output stationPktT int0Pkt,
	output stationPktT int1Pkt,
	output stationPktT loadPkt,
	output stationPktT storePkt
);
	intOpE slotOp [`ISSUE_WIDTH];
	logic [immW-1:0] slotImm [`ISSUE_WIDTH];
	regIdxT slotRs [`ISSUE_WIDTH];
	regIdxT slotRt [`ISSUE_WIDTH];
	stationPktT pktD [4];
	stationPktT pktQ [4];
	logic [`ISSUE_WIDTH-1:0] hitMask [4]; // Slots granted to each station

	for (genvar k = 0; k < `ISSUE_WIDTH; k++)
	begin : gSlot
		assign slotOp[k] = slots[k].intOp;
		assign slotImm[k] = slots[k].imm;
		assign slotRs[k] = slots[k].rs;
		assign slotRt[k] = slots[k].rt;
	end

	always_comb
	begin
		for (int s = 0; s < 4; s++)
		begin
			pktD[s] = '0;
			hitMask[s] = '0;
		end
		for (int k = 0; k < `ISSUE_WIDTH; k++)
		begin
			if (grants.grant[k])
			begin
				hitMask[grants.station[k]][k] = 1'b1;
				pktD[grants.station[k]].valid = 1'b1;
				pktD[grants.station[k]].intOp =
					(grants.station[k] == stInt0 || grants.station[k] == stInt1) ?
					slotOp[k] : opNop; // Memory stations carry no ALU op
				pktD[grants.station[k]].imm = slotImm[k];
				pktD[grants.station[k]].srcA = slotRs[k];
				pktD[grants.station[k]].srcB = slotRt[k];
				pktD[grants.station[k]].tag = slotTag(robHead, k);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int s = 0; s < 4; s++)
				pktQ[s].valid <= 1'b0;
		end
		else
			pktQ <= pktD;
	end

	assign int0Pkt = pktQ[stInt0];
	assign int1Pkt = pktQ[stInt1];
	assign loadPkt = pktQ[stLoad];
	assign storePkt = pktQ[stStore];

	// Arbiter must never hand one station two slots
	for (genvar s = 0; s < 4; s++)
	begin : gOneGrant
		assert property (@(posedge clk) disable iff (rst) $onehot0(hitMask[s]));
	end

endmodule

// File: design/robAllocator.sv
// Registers the ROB entries, rename writes, issue count and next fetch PC for each bundle
`timescale 1ns/1ps
`include "decode_params.svh"

module robAllocator
	import issuePkg::*;
(
	input logic clk,
	input logic rst,
	slotIf.sink slots [`ISSUE_WIDTH],
	grantIf.sink grants,
	input logic [robHeadW-1:0] robHead,
	input logic [4:0] robFree,
	input logic [31:0] fetchPc,
	output robEntryT robEntry [`ISSUE_WIDTH],
	output renameT rename [`ISSUE_WIDTH],
	output logic [2:0] issueCount,
	output logic [31:0] pcNext
);
	instClassE slotCls [`ISSUE_WIDTH];
	logic [4:0] slotDest [`ISSUE_WIDTH];
	logic slotWrites [`ISSUE_WIDTH];
	logic [15:0] slotImm [`ISSUE_WIDTH];
	robEntryT robD [`ISSUE_WIDTH];
	renameT renD [`ISSUE_WIDTH];

	for (genvar k = 0; k < `ISSUE_WIDTH; k++)
	begin : gSlot
		assign slotCls[k] = slots[k].cls;
		assign slotDest[k] = slots[k].destReg;
		assign slotWrites[k] = slots[k].writesReg;
		assign slotImm[k] = slots[k].imm;
	end

	always_comb
	begin
		for (int k = 0; k < `ISSUE_WIDTH; k++)
		begin
			robD[k].valid = grants.grant[k];
			robD[k].opType = robArith; // Loads included
			robD[k].dest = 32'(slotDest[k]);
			case (slotCls[k])
				clsBranch:
				begin
					robD[k].opType = robBranch;
					// Target from this slot's own PC plus word offset
					robD[k].dest = fetchPc - 32'(`PC_FETCH_LEAD) + (32'(k) << 2) +
						{{14{slotImm[k][15]}}, slotImm[k], 2'b00};
				end
				clsStore:
				begin
					robD[k].opType = robStore;
					robD[k].dest = '0;
				end
				default: ;
			endcase
			renD[k].valid = grants.grant[k] && slotWrites[k];
			renD[k].regId = slotDest[k];
			renD[k].tag = slotTag(robHead, k);
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int k = 0; k < `ISSUE_WIDTH; k++)
			begin
				robEntry[k].valid <= 1'b0;
				rename[k].valid <= 1'b0;
			end
			issueCount <= '0;
			pcNext <= '0;
		end
		else
		begin
			robEntry <= robD;
			rename <= renD;
			issueCount <= grants.count;
			pcNext <= fetchPc + (32'(grants.count) << 2); // One word per issued instruction
		end
	end

	// Registered count stays within the ROB space seen when the bundle was taken
	assert property (@(posedge clk) disable iff (rst) 5'(issueCount) <= $past(robFree));

endmodule

// File: design/issueTop.sv
// Issue-stage top level with plain ports; connect the instruction buffer, ROB and stations here
`timescale 1ns/1ps
`include "decode_params.svh"

module issueTop
	import issuePkg::*;
(
	input logic clk,
	input logic rst,
	input logic [31:0] instWord [`ISSUE_WIDTH],
	input logic [`ISSUE_WIDTH-1:0] instValid,
	input logic [4:0] robFree,
	input logic [robHeadW-1:0] robHead,
	input logic int0Busy,
	input logic int1Busy,
	input logic loadBusy,
	input logic storeBusy,
	input logic [31:0] fetchPc,
	output logic int0Valid,
	output logic [4:0] int0Op,
	output logic [15:0] int0Imm,
	output logic [4:0] int0SrcA,
	output logic [4:0] int0SrcB,
	output logic [`TAG_W-1:0] int0Tag,
	output logic int1Valid,
	output logic [4:0] int1Op,
	output logic [15:0] int1Imm,
	output logic [4:0] int1SrcA,
	output logic [4:0] int1SrcB,
	output logic [`TAG_W-1:0] int1Tag,
	output logic loadValid,
	output logic [4:0] loadOp,
	output logic [15:0] loadImm,
	output logic [4:0] loadSrcA,
	output logic [4:0] loadSrcB,
	output logic [`TAG_W-1:0] loadTag,
	output logic storeValid,
	output logic [4:0] storeOp,
	output logic [15:0] storeImm,
	output logic [4:0] storeSrcA,
	output logic [4:0] storeSrcB,
	output logic [`TAG_W-1:0] storeTag,
	output logic robValid [`ISSUE_WIDTH],
	output logic [2:0] robOpType [`ISSUE_WIDTH],
	output logic [31:0] robDest [`ISSUE_WIDTH],
	output logic renameValid [`ISSUE_WIDTH],
	output logic [4:0] renameReg [`ISSUE_WIDTH],
	output logic [`TAG_W-1:0] renameTag [`ISSUE_WIDTH],
	output logic [2:0] issueCount,
	output logic [31:0] pcNext
);
	stationPktT int0Pkt;
	stationPktT int1Pkt;
	stationPktT loadPkt;
	stationPktT storePkt;
	robEntryT robEntry [`ISSUE_WIDTH];
	renameT rename [`ISSUE_WIDTH];

	slotIf slots [`ISSUE_WIDTH] ();
	grantIf grants ();

	for (genvar k = 0; k < `ISSUE_WIDTH; k++)
	begin : gDec
		slotDecoder uDec (
			.instWord(instWord[k]),
			.instValid(instValid[k]),
			.slot(slots[k])
		);

		assign robValid[k] = robEntry[k].valid;
		assign robOpType[k] = robEntry[k].opType;
		assign robDest[k] = robEntry[k].dest;
		assign renameValid[k] = rename[k].valid;
		assign renameReg[k] = rename[k].regId;
		assign renameTag[k] = rename[k].tag;
	end

	issueArbiter uArb (
		.clk(clk),
		.rst(rst),
		.slots(slots),
		.robFree(robFree),
		.int0Busy(int0Busy),
		.int1Busy(int1Busy),
		.loadBusy(loadBusy),
		.storeBusy(storeBusy),
		.grants(grants)
	);

	stationDispatch uDisp (
		.clk(clk),
		.rst(rst),
		.slots(slots),
		.grants(grants),
		.robHead(robHead),
		.int0Pkt(int0Pkt),
		.int1Pkt(int1Pkt),
		.loadPkt(loadPkt),
		.storePkt(storePkt)
	);

	robAllocator uRob (
		.clk(clk),
		.rst(rst),
		.slots(slots),
		.grants(grants),
		.robHead(robHead),
		.robFree(robFree),
		.fetchPc(fetchPc),
		.robEntry(robEntry),
		.rename(rename),
		.issueCount(issueCount),
		.pcNext(pcNext)
	);

	// Station packets out as flat fields
	assign int0Valid = int0Pkt.valid;
	assign int0Op = int0Pkt.intOp;
	assign int0Imm = int0Pkt.imm;
	assign int0SrcA = int0Pkt.srcA;
	assign int0SrcB = int0Pkt.srcB;
	assign int0Tag = int0Pkt.tag;
	assign int1Valid = int1Pkt.valid;
	assign int1Op = int1Pkt.intOp;
	assign int1Imm = int1Pkt.imm;
	assign int1SrcA = int1Pkt.srcA;
	assign int1SrcB = int1Pkt.srcB;
	assign int1Tag = int1Pkt.tag;
	assign loadValid = loadPkt.valid;
	assign loadOp = loadPkt.intOp;
	assign loadImm = loadPkt.imm;
	assign loadSrcA = loadPkt.srcA;
	assign loadSrcB = loadPkt.srcB;
	assign loadTag = loadPkt.tag;
	assign storeValid = storePkt.valid;
	assign storeOp = storePkt.intOp;
	assign storeImm = storePkt.imm;
	assign storeSrcA = storePkt.srcA;
	assign storeSrcB = storePkt.srcB;
	assign storeTag = storePkt.tag;

endmodule

// File: verification/issueTb.sv
// Self-checking testbench for the issue stage; a reference model feeds concurrent assertions
`timescale 1ns/1ps
`include "decode_params.svh"

module issueTb
	import isaPkg::*;
	import issuePkg::*;
();
	logic clk;
	logic rst;
	logic [31:0] instWord [`ISSUE_WIDTH];
	logic [`ISSUE_WIDTH-1:0] instValid;
	logic [4:0] robFree;
	logic [2:0] robHead;
	logic int0Busy;
	logic int1Busy;
	logic loadBusy;
	logic storeBusy;
	logic [31:0] fetchPc;
	logic int0Valid, int1Valid, loadValid, storeValid;
	logic [4:0] int0Op, int1Op, loadOp, storeOp;
	logic [15:0] int0Imm, int1Imm, loadImm, storeImm;
	logic [4:0] int0SrcA, int1SrcA, loadSrcA, storeSrcA;
	logic [4:0] int0SrcB, int1SrcB, loadSrcB, storeSrcB;
	logic [`TAG_W-1:0] int0Tag, int1Tag, loadTag, storeTag;
	logic robValid [`ISSUE_WIDTH];
	logic [2:0] robOpType [`ISSUE_WIDTH];
	logic [31:0] robDest [`ISSUE_WIDTH];
	logic renameValid [`ISSUE_WIDTH];
	logic [4:0] renameReg [`ISSUE_WIDTH];
	logic [`TAG_W-1:0] renameTag [`ISSUE_WIDTH];
	logic [2:0] issueCount;
	logic [31:0] pcNext;

	// Fields are compared only where the valid bit is set
	logic [37:0] gotPkt [4];
	logic [37:0] expPkt [4];
	logic [35:0] gotRob [`ISSUE_WIDTH];
	logic [35:0] expRob [`ISSUE_WIDTH];
	logic [11:0] gotRen [`ISSUE_WIDTH];
	logic [11:0] expRen [`ISSUE_WIDTH];
	logic [2:0] expCount;
	logic [31:0] expPc;
	logic armed;
	int applySeq = 0; // Bundles driven
	int expSeq = 0;
	int checkSeq = 0; // Bundles whose outputs were compared
	int errCount = 0;
	int errMark = 0;
	int passCount = 0;
	int failCount = 0;
	logic [31:0] lcgState = 32'hc491;

	issueTop UUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic logic [31:0] rType(input functE fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		return {6'h00, rs, rt, rd, 5'h00, fn};
	endfunction

	function automatic logic [31:0] iType(input opcodeE opc, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {opc, rs, rt, imm};
	endfunction

	function automatic instClassE classOf(input logic [31:0] w);
		case (w[31:26])
			opcLw: return clsLoad;
			opcSw: return clsStore;
			opcBeq, opcBne: return clsBranch;
			default: return clsArith;
		endcase
	endfunction

	function automatic logic [4:0] opOf(input logic [31:0] w);
		logic [4:0] op;
		op = opNop;
		case (w[31:26])
			opcRtype:
			begin
				case (w[5:0])
					fnAdd: op = opAdd;
					fnSub: op = opSub;
					fnAnd: op = opAnd;
					fnOr: op = opOr;
					fnSlt: op = opSlt;
					default: op = opNop;
				endcase
			end
			opcAddi: op = opAddi;
			opcSlti: op = opSlti;
			opcAndi: op = opAndi;
			opcOri: op = opOri;
			opcBeq: op = opBeq;
			opcBne: op = opBne;
			default: op = opNop;
		endcase
		return op;
	endfunction

	function automatic robOpE robOpOf(input instClassE cls);
		case (cls)
			clsBranch: return robBranch;
			clsStore: return robStore;
			default: return robArith; // Loads too
		endcase
	endfunction

	function automatic string pktName(input int s);
		case (s)
			0: return "int0Pkt";
			1: return "int1Pkt";
			2: return "loadPkt";
			default: return "storePkt";
		endcase
	endfunction

	// Reference model with the same single register stage as the DUT
	always @(posedge clk)
	begin : refModel
		logic [37:0] pktN [4];
		logic [35:0] robN [`ISSUE_WIDTH];
		logic [11:0] renN [`ISSUE_WIDTH];
		logic [3:0] busyVec;
		logic [3:0] taken;
		logic blocked;
		logic grant;
		logic [2:0] cnt;
		logic [31:0] w;
		instClassE cls;
		logic [4:0] op;
		logic [4:0] dst;
		stationE st;
		logic [5:0] tag;
		logic [31:0] robDst;
		busyVec = {storeBusy, loadBusy, int1Busy, int0Busy};
		taken = '0;
		blocked = 1'b0;
		cnt = '0;
		for (int s = 0; s < 4; s++)
			pktN[s] = '0;
		for (int k = 0; k < `ISSUE_WIDTH; k++)
		begin
			w = instWord[k];
			cls = classOf(w);
			op = opOf(w);
			case (w[31:26])
				opcAddi, opcSlti, opcAndi, opcOri, opcLw: dst = w[20:16]; // I-format writes rt
				default: dst = w[15:11];
			endcase
			case (cls)
				clsLoad: st = stLoad;
				clsStore: st = stStore;
				default: st = (busyVec[stInt0] || taken[stInt0]) ? stInt1 : stInt0;
			endcase
			grant = !blocked && instValid[k] && robFree > 5'(k) && !busyVec[st] && !taken[st];
			tag = 6'((int'(robHead) + k) % `ROB_ENTRIES + 1);
			case (cls)
				clsBranch: robDst = fetchPc - 32'(`PC_FETCH_LEAD) + 32'(4 * k) +
					{{14{w[15]}}, w[15:0], 2'b00};
				clsStore: robDst = '0;
				default: robDst = 32'(dst);
			endcase
			robN[k] = '0;
			renN[k] = '0;
			if (grant)
			begin
				taken[st] = 1'b1;
				cnt++;
				pktN[st] = {1'b1, (st == stLoad || st == stStore) ? 5'(opNop) : op,
					w[15:0], w[25:21], w[20:16], tag};
				robN[k] = {1'b1, robOpOf(cls), robDst};
				if (cls == clsArith || cls == clsLoad)
					renN[k] = {1'b1, dst, tag};
			end
			else
				blocked = 1'b1; // Nothing after this slot issues
		end
		for (int s = 0; s < 4; s++)
			expPkt[s] <= rst ? '0 : pktN[s];
		for (int k = 0; k < `ISSUE_WIDTH; k++)
		begin
			expRob[k] <= rst ? '0 : robN[k];
			expRen[k] <= rst ? '0 : renN[k];
		end
		expCount <= rst ? '0 : cnt;
		expPc <= rst ? '0 : fetchPc + 32'(4 * int'(cnt));
		expSeq <= applySeq;
	end

	always @(posedge clk)
		checkSeq <= expSeq; // Advances once the assertions have seen the bundle

	assign gotPkt[0] = int0Valid ? {int0Valid, int0Op, int0Imm, int0SrcA, int0SrcB, int0Tag} : '0;
	assign gotPkt[1] = int1Valid ? {int1Valid, int1Op, int1Imm, int1SrcA, int1SrcB, int1Tag} : '0;
	assign gotPkt[2] = loadValid ? {loadValid, loadOp, loadImm, loadSrcA, loadSrcB, loadTag} : '0;
	assign gotPkt[3] = storeValid ?
		{storeValid, storeOp, storeImm, storeSrcA, storeSrcB, storeTag} : '0;

	for (genvar s = 0; s < 4; s++)
	begin : gPktChk
		assert property (@(posedge clk) disable iff (!armed) gotPkt[s] == expPkt[s])
		else
		begin
			errCount++;
			$display("Fail %s got %h exp %h", pktName(s), $sampled(gotPkt[s]),
				$sampled(expPkt[s]));
		end
	end

	for (genvar k = 0; k < `ISSUE_WIDTH; k++)
	begin : gSlotChk
		assign gotRob[k] = robValid[k] ? {1'b1, robOpType[k], robDest[k]} : '0;
		assign gotRen[k] = renameValid[k] ? {1'b1, renameReg[k], renameTag[k]} : '0;
		assert property (@(posedge clk) disable iff (!armed) gotRob[k] == expRob[k])
		else
		begin
			errCount++;
			$display("Fail robEntry[%0d] got %h exp %h", k, $sampled(gotRob[k]),
				$sampled(expRob[k]));
		end
		assert property (@(posedge clk) disable iff (!armed) gotRen[k] == expRen[k])
		else
		begin
			errCount++;
			$display("Fail rename[%0d] got %h exp %h", k, $sampled(gotRen[k]),
				$sampled(expRen[k]));
		end
	end

	assert property (@(posedge clk) disable iff (!armed) issueCount == expCount)
	else
	begin
		errCount++;
		$display("Fail issueCount got %h exp %h", $sampled(issueCount), $sampled(expCount));
	end

	assert property (@(posedge clk) disable iff (!armed) pcNext == expPc)
	else
	begin
		errCount++;
		$display("Fail pcNext got %h exp %h", $sampled(pcNext), $sampled(expPc));
	end

	// busy is {store, load, int1, int0}
	task automatic applyBundle(input logic [31:0] w0, input logic [31:0] w1,
		input logic [31:0] w2, input logic [31:0] w3, input logic [3:0] valid,
		input logic [4:0] free, input logic [2:0] head, input logic [3:0] busy,
		input logic [31:0] pc);
		@(posedge clk);
		#1;
		instWord[0] = w0;
		instWord[1] = w1;
		instWord[2] = w2;
		instWord[3] = w3;
		instValid = valid;
		robFree = free;
		robHead = head;
		{storeBusy, loadBusy, int1Busy, int0Busy} = busy;
		fetchPc = pc;
		applySeq++;
	endtask

	task automatic waitChecked();
		int waited;
		waited = 0;
		while (checkSeq != applySeq && waited < 10)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (checkSeq != applySeq)
		begin
			$display("Timeout: bundle %0d never reached the output checks", applySeq);
			$display("Regression failed");
			$finish;
		end
	endtask

	task automatic finishTest(input string name);
		int errs;
		waitChecked();
		errs = errCount - errMark;
		errMark = errCount;
		if (errs == 0)
		begin
			passCount++;
			$display("Test %s: ok", name);
		end
		else
		begin
			failCount++;
			$display("Test %s: %0d mismatches", name, errs);
		end
	endtask

	function automatic logic [31:0] randomInst(input logic [31:0] r);
		int sel;
		functE fn;
		sel = int'(r[31:28]) % 9;
		case (int'(r[11:9]) % 5)
			0: fn = fnAdd;
			1: fn = fnSub;
			2: fn = fnAnd;
			3: fn = fnOr;
			default: fn = fnSlt;
		endcase
		case (sel)
			0: return rType(fn, r[27:23], r[22:18], r[17:13]);
			1: return iType(opcAddi, r[27:23], r[22:18], r[15:0]);
			2: return iType(opcSlti, r[27:23], r[22:18], r[15:0]);
			3: return iType(opcAndi, r[27:23], r[22:18], r[15:0]);
			4: return iType(opcOri, r[27:23], r[22:18], r[15:0]);
			5: return iType(opcBeq, r[27:23], r[22:18], r[15:0]);
			6: return iType(opcBne, r[27:23], r[22:18], r[15:0]);
			7: return iType(opcLw, r[27:23], r[22:18], r[15:0]);
			default: return iType(opcSw, r[27:23], r[22:18], r[15:0]);
		endcase
	endfunction

	task automatic randomBundle();
		logic [31:0] w [4];
		logic [31:0] c1;
		logic [31:0] c2;
		logic [31:0] p;
		for (int k = 0; k < 4; k++)
			w[k] = randomInst(nextRand());
		c1 = nextRand();
		c2 = nextRand();
		p = nextRand();
		// Slots valid 3 in 4, each station busy 1 in 4
		applyBundle(w[0], w[1], w[2], w[3], c1[31:28] | c1[27:24], 5'(c1[23:20] % 9),
			c1[19:17], c2[31:28] & c2[27:24], {p[31:2], 2'b00});
	endtask

	initial
	begin
		rst = 1'b1;
		armed = 1'b0;
		// Live bundle held through reset so that only reset keeps the outputs clear
		for (int k = 0; k < `ISSUE_WIDTH; k++)
			instWord[k] = iType(opcAddi, 5'(k), 5'(k + 1), 16'h0004);
		instValid = 4'b1111;
		robFree = 5'd8;
		robHead = '0;
		{storeBusy, loadBusy, int1Busy, int0Busy} = 4'b0000;
		fetchPc = 32'h0000_0800;
		@(posedge clk);
		#1;
		armed = 1'b1; // Outputs known from the first reset edge on
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		applyBundle('0, '0, '0, '0, 4'b0000, 5'd8, 3'd0, 4'b0000, 32'h0);
		finishTest("reset");

		// lw, sw, add, addi with head 6 so tags wrap past 8
		applyBundle(iType(opcLw, 5'd1, 5'd2, 16'h0010), iType(opcSw, 5'd3, 5'd4, 16'hfff8),
			rType(fnAdd, 5'd5, 5'd6, 5'd7), iType(opcAddi, 5'd8, 5'd9, 16'h0123),
			4'b1111, 5'd8, 3'd6, 4'b0000, 32'h0040_0100);
		applyBundle(iType(opcLw, 5'd1, 5'd2, 16'h0010), iType(opcSw, 5'd3, 5'd4, 16'hfff8),
			rType(fnAdd, 5'd5, 5'd6, 5'd7), iType(opcAddi, 5'd8, 5'd9, 16'h0123),
			4'b1111, 5'd8, 3'd1, 4'b0000, 32'h0040_0200);
		finishTest("full bundle");

		applyBundle(iType(opcLw, 5'd1, 5'd2, 16'h0004), iType(opcLw, 5'd3, 5'd4, 16'h0008),
			rType(fnAdd, 5'd5, 5'd6, 5'd7), rType(fnSub, 5'd8, 5'd9, 5'd10),
			4'b1111, 5'd8, 3'd0, 4'b0000, 32'h0000_1000);
		applyBundle(rType(fnAdd, 5'd1, 5'd2, 5'd3), rType(fnSub, 5'd4, 5'd5, 5'd6),
			rType(fnAnd, 5'd7, 5'd8, 5'd9), rType(fnOr, 5'd10, 5'd11, 5'd12),
			4'b1111, 5'd8, 3'd3, 4'b0000, 32'h0000_2000);
		applyBundle(rType(fnSlt, 5'd1, 5'd2, 5'd3), iType(opcSw, 5'd4, 5'd5, 16'h0020),
			iType(opcLw, 5'd6, 5'd7, 16'h0030), rType(fnSub, 5'd8, 5'd9, 5'd10),
			4'b1111, 5'd8, 3'd7, 4'b0001, 32'h0000_3000);
		finishTest("structural stall");

		applyBundle(rType(fnAdd, 5'd1, 5'd2, 5'd3), iType(opcLw, 5'd4, 5'd5, 16'h0040),
			iType(opcSw, 5'd6, 5'd7, 16'h0044), rType(fnOr, 5'd8, 5'd9, 5'd10),
			4'b1111, 5'd2, 3'd4, 4'b0000, 32'h0000_4000);
		applyBundle(rType(fnAdd, 5'd1, 5'd2, 5'd3), iType(opcLw, 5'd4, 5'd5, 16'h0040),
			iType(opcSw, 5'd6, 5'd7, 16'h0044), rType(fnOr, 5'd8, 5'd9, 5'd10),
			4'b1101, 5'd8, 3'd4, 4'b0000, 32'h0000_4010);
		finishTest("rob limit");

		applyBundle(iType(opcBeq, 5'd1, 5'd2, 16'hfffc), iType(opcLw, 5'd3, 5'd4, 16'h0008),
			iType(opcSw, 5'd5, 5'd6, 16'h000c), iType(opcBne, 5'd7, 5'd8, 16'h0020),
			4'b1111, 5'd8, 3'd5, 4'b0000, 32'h0000_5000);
		finishTest("branches");

		for (int n = 0; n < 300; n++)
			randomBundle();
		finishTest("random");

		$display("Tests passed %0d, failed %0d, mismatches %0d", passCount, failCount,
			errCount);
		if (failCount == 0 && errCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: build.f
+incdir+design
design/isaPkg.sv
design/issuePkg.sv
design/issueIfs.sv
design/slotDecoder.sv
design/issueArbiter.sv
design/stationDispatch.sv
design/robAllocator.sv
design/issueTop.sv
verification/issueTb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile with Verilator and run; exit status follows the testbench verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module issueTb -o issueSim || exit 1
simOut="$(./obj_dir/issueSim)"
echo "$simOut"
echo "$simOut" | grep -qx "Regression passed" && echo "Simulation ok" || { echo "Simulation not ok"; exit 1; }
